// File: sim.f
verilog/exec_pkg.sv
verilog/operand_forward.sv
verilog/int_alu.sv
verilog/iter_divider.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/execute_unit.sv
dv/tb_clock.sv
dv/execute_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module execute_tb \
  --Mdir obj_dir -o execute_tb

output=$(./obj_dir/execute_tb 2>&1 || true)
echo "$output"
echo "$output" | grep -q "Simulation finished: PASS"

// File: dv/execute_tb.sv
`timescale 1ns/1ps
`default_nettype none

module execute_tb;

  localparam int xlen = 32;
  localparam int addr_w = exec_pkg::REG_ADDR_W;
  localparam int shamt_w = $clog2(xlen);
  localparam int period_ns = 10;
  localparam int reset_cycles = 16;
  localparam int num_random = 200;
  localparam int num_directed = 100;
  localparam int watchdog_ns =
    (reset_cycles + (num_random + num_directed) * (xlen + 4)) * period_ns;

  logic                  clock;
  logic                  reset;
  logic                  issue_valid;
  exec_pkg::alu_op_t     issue_op;
  logic [addr_w-1:0]     issue_rs1;
  logic [addr_w-1:0]     issue_rs2;
  logic [addr_w-1:0]     issue_rd;
  logic [xlen-1:0]       issue_imm;
  logic                  issue_use_imm;
  logic                  flush;
  logic                  stall;
  logic                  result_valid;
  logic [addr_w-1:0]     result_rd;
  logic [xlen-1:0]       result_data;

  logic [xlen-1:0]       model_regs [exec_pkg::NUM_REGS];
  logic [addr_w-1:0]     exp_rd_q [$];
  logic [xlen-1:0]       exp_data_q [$];
  logic [31:0]           lfsr_state = 32'd8;

  tb_clock #(.period_ns(period_ns), .reset_cycles(reset_cycles)) u_clock (
    .clock (clock),
    .reset (reset)
  );

  execute_unit #(.xlen(xlen)) uut (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_rd      (issue_rd),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm),
    .flush         (flush),
    .stall         (stall),
    .result_valid  (result_valid),
    .result_rd     (result_rd),
    .result_data   (result_data)
  );

  // galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [xlen-1:0] rand_bits(input int n);
    logic [xlen-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[xlen-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [addr_w-1:0] rand_reg();
    logic [xlen-1:0] v;
    v = rand_bits(addr_w);
    return v[addr_w-1:0];
  endfunction

  function automatic logic rand_flag();
    logic [xlen-1:0] v;
    v = rand_bits(1);
    return v[0];
  endfunction

  function automatic exec_pkg::alu_op_t rand_op(input int num_ops);
    logic [xlen-1:0] v;
    v = rand_bits(4) % xlen'(num_ops);
    return exec_pkg::alu_op_t'(v[3:0]);
  endfunction

  function automatic logic [xlen-1:0] ref_result(input exec_pkg::alu_op_t op,
                                                 input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
    logic [shamt_w-1:0] sh;
    logic [xlen-1:0]    sign;
    sh = b[shamt_w-1:0];
    sign = {1'b1, {(xlen-1){1'b0}}};
    case (op)
      exec_pkg::OP_ADD:  return a + b;
      exec_pkg::OP_SUB:  return a - b;
      exec_pkg::OP_AND:  return a & b;
      exec_pkg::OP_OR:   return a | b;
      exec_pkg::OP_XOR:  return a ^ b;
      exec_pkg::OP_SLL:  return a << sh;
      exec_pkg::OP_SRL:  return a >> sh;
      exec_pkg::OP_SRA:  return (a >> sh) | (a[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0);
      exec_pkg::OP_SLT:  return {{(xlen-1){1'b0}}, (a ^ sign) < (b ^ sign)}; // biased compare.
      exec_pkg::OP_SLTU: return {{(xlen-1){1'b0}}, a < b};
      exec_pkg::OP_LUI:  return b;
      exec_pkg::OP_DIVU: return (b == '0) ? '1 : a / b;
      exec_pkg::OP_REMU: return (b == '0) ? a : a % b;
      default:           return '0;
    endcase
  endfunction

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic drive_issue(input exec_pkg::alu_op_t op, input logic [addr_w-1:0] rs1, rs2, rd,
                             input logic [xlen-1:0] imm, input logic use_imm);
    issue_valid = 1'b1;
    issue_op = op;
    issue_rs1 = rs1;
    issue_rs2 = rs2;
    issue_rd = rd;
    issue_imm = imm;
    issue_use_imm = use_imm;
  endtask

  task automatic drain();
    while (exp_rd_q.size() != 0) next_cycle();
  endtask

  task automatic issue_instr(input exec_pkg::alu_op_t op, input logic [addr_w-1:0] rs1, rs2, rd,
                             input logic [xlen-1:0] imm, input logic use_imm);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] expected;
    while (stall) next_cycle();
    drive_issue(op, rs1, rs2, rd, imm, use_imm);
    a = model_regs[rs1];
    b = use_imm ? imm : model_regs[rs2];
    expected = ref_result(op, a, b);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(expected);
    if (rd != '0) begin
      model_regs[rd] = expected; // x0 stays zero.
    end
    next_cycle();
    issue_valid = 1'b0;
  endtask

  task automatic divide_checked(input exec_pkg::alu_op_t op, input logic [addr_w-1:0] rs1, rs2, rd,
                                input logic [xlen-1:0] imm, input logic use_imm);
    int waited;
    drain();
    issue_instr(op, rs1, rs2, rd, imm, use_imm);
    assert (stall) else begin
      $display("stall did not rise after a divide was accepted");
      stop_with_failure();
    end
    while (stall) begin
      assert (!result_valid) else begin
        $display("an instruction retired while the divider held stall");
        stop_with_failure();
      end
      next_cycle();
    end
    waited = 0;
    while (!result_valid && waited < 4) begin
      next_cycle();
      waited++;
    end
    assert (result_valid) else begin
      $display("no divide result arrived after stall fell");
      stop_with_failure();
    end
  endtask

  // the killed instruction never enters the model or the queue.
  task automatic issue_and_flush(input exec_pkg::alu_op_t op, input logic [addr_w-1:0] rs1, rs2, rd,
                                 input logic [xlen-1:0] imm, input logic use_imm,
                                 input int hold_cycles);
    drain();
    drive_issue(op, rs1, rs2, rd, imm, use_imm);
    next_cycle();
    issue_valid = 1'b0;
    repeat (hold_cycles) next_cycle();
    assert (hold_cycles == 0 || stall) else begin
      $display("stall fell before the divide could be flushed");
      stop_with_failure();
    end
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    assert (!stall) else begin
      $display("stall still high after a flush");
      stop_with_failure();
    end
    repeat (3) next_cycle();
  endtask

  always @(negedge clock) begin : compare_results
    logic [addr_w-1:0] want_rd;
    logic [xlen-1:0]   want_data;
    if (reset && result_valid) begin
      assert (exp_rd_q.size() != 0) else begin
        $display("result_valid with no instruction outstanding");
        stop_with_failure();
      end
      want_rd = exp_rd_q.pop_front();
      want_data = exp_data_q.pop_front();
      assert (result_rd == want_rd) else begin
        $display("MISMATCH result_rd: got %h expected %h", result_rd, want_rd);
        stop_with_failure();
      end
      assert (result_data == want_data) else begin
        $display("MISMATCH result_data: got %h expected %h", result_data, want_data);
        stop_with_failure();
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    stop_with_failure();
  end

  initial begin
    logic [xlen-1:0]   v;
    logic [addr_w-1:0] rd_prev1;
    logic [addr_w-1:0] rd_prev2;
    logic [addr_w-1:0] rd_next;
    issue_valid = 1'b0;
    issue_op = exec_pkg::OP_ADD;
    issue_rs1 = '0;
    issue_rs2 = '0;
    issue_rd = '0;
    issue_imm = '0;
    issue_use_imm = 1'b0;
    flush = 1'b0;
    for (int i = 0; i < exec_pkg::NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    wait (reset === 1'b1);
    next_cycle();

    // random contents for x1 to x15.
    for (int i = 1; i < exec_pkg::NUM_REGS; i++) begin
      issue_instr(exec_pkg::OP_LUI, 4'd0, 4'd0, i[addr_w-1:0], rand_bits(xlen), 1'b1);
    end
    for (int k = 0; k < 11; k++) begin
      repeat (4) begin
        issue_instr(exec_pkg::alu_op_t'(k[3:0]), rand_reg(), rand_reg(), rand_reg(),
                    rand_bits(xlen), rand_flag());
      end
    end

    // each source depends on one of the two instructions before.
    rd_prev2 = rand_reg();
    rd_prev1 = rand_reg();
    repeat (12) begin
      rd_next = rand_reg();
      issue_instr(rand_op(11), rd_prev1, rd_prev2, rd_next, '0, 1'b0);
      rd_prev2 = rd_prev1;
      rd_prev1 = rd_next;
    end

    divide_checked(exec_pkg::OP_DIVU, rand_reg(), rand_reg(), rand_reg(), '0, 1'b0);
    divide_checked(exec_pkg::OP_REMU, rand_reg(), rand_reg(), rand_reg(), '0, 1'b0);
    divide_checked(exec_pkg::OP_DIVU, rand_reg(), 4'd0, rand_reg(), rand_bits(6), 1'b1);
    divide_checked(exec_pkg::OP_REMU, rand_reg(), 4'd0, rand_reg(), rand_bits(6), 1'b1);
    divide_checked(exec_pkg::OP_DIVU, 4'd5, 4'd0, 4'd6, '0, 1'b1); // divide by zero.
    divide_checked(exec_pkg::OP_REMU, 4'd7, 4'd0, 4'd8, '0, 1'b0);

    issue_instr(exec_pkg::OP_ADD, 4'd3, 4'd0, 4'd0, xlen'(16'h1357), 1'b1);
    issue_instr(exec_pkg::OP_OR, 4'd0, 4'd0, 4'd7, '0, 1'b0);
    next_cycle();
    next_cycle();
    issue_instr(exec_pkg::OP_ADD, 4'd0, 4'd0, 4'd8, '0, 1'b0);

    issue_and_flush(exec_pkg::OP_ADD, 4'd1, 4'd2, 4'd9, '0, 1'b0, 0);
    issue_instr(exec_pkg::OP_OR, 4'd9, 4'd0, 4'd10, '0, 1'b0);
    issue_and_flush(exec_pkg::OP_DIVU, 4'd3, 4'd4, 4'd11, '0, 1'b0, 0);
    issue_and_flush(exec_pkg::OP_REMU, 4'd3, 4'd4, 4'd11, '0, 1'b0, 9);
    issue_instr(exec_pkg::OP_OR, 4'd11, 4'd0, 4'd12, '0, 1'b0);

    repeat (num_random) begin
      v = rand_bits(3);
      if (v[2:0] == 3'd0) begin
        next_cycle(); // idle gap.
      end
      issue_instr(rand_op(13), rand_reg(), rand_reg(), rand_reg(), rand_bits(xlen), rand_flag());
    end

    // a divide may still be in flight.
    for (int n = 0; n < xlen + 4 && exp_rd_q.size() != 0; n++) begin
      next_cycle();
    end
    repeat (4) next_cycle();
    if (exp_rd_q.size() == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("%0d instructions never retired", exp_rd_q.size());
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns = 10,
  parameter int reset_cycles = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
  end

  // active low, released just after an edge.
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b1;
  end

endmodule

`default_nettype wire

// File: verilog/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit #(
  parameter int xlen = 32
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            issue_valid,
  input  exec_pkg::alu_op_t               issue_op,
  input  logic [exec_pkg::REG_ADDR_W-1:0] issue_rs1,
  input  logic [exec_pkg::REG_ADDR_W-1:0] issue_rs2,
  input  logic [exec_pkg::REG_ADDR_W-1:0] issue_rd,
  input  logic [xlen-1:0]                 issue_imm,
  input  logic                            issue_use_imm,
  input  logic                            flush,
  output logic                            stall,
  output logic                            result_valid,
  output logic [exec_pkg::REG_ADDR_W-1:0] result_rd,
  output logic [xlen-1:0]                 result_data
);

  logic [exec_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [exec_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [xlen-1:0]                 rf_data1;
  logic [xlen-1:0]                 rf_data2;
  logic [xlen-1:0]                 op_a;
  logic [xlen-1:0]                 op_b;
  exec_pkg::alu_op_t               alu_op;
  logic [xlen-1:0]                 alu_a;
  logic [xlen-1:0]                 alu_b;
  logic [xlen-1:0]                 alu_result;
  logic                            div_start;
  logic                            div_abort;
  logic                            div_want_rem;
  logic                            div_ready;
  logic [xlen-1:0]                 div_result;

  operand_forward #(.xlen(xlen)) u_forward (
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rf_data1  (rf_data1),
    .rf_data2  (rf_data2),
    .fwd_valid (result_valid),
    .fwd_rd    (result_rd),
    .fwd_data  (result_data),
    .op_a      (op_a),
    .op_b      (op_b)
  );

  int_alu #(.xlen(xlen)) u_alu (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  iter_divider #(.xlen(xlen)) u_divider (
    .clock    (clock),
    .reset    (reset),
    .start    (div_start),
    .abort    (div_abort),
    .want_rem (div_want_rem),
    .dividend (alu_a),
    .divisor  (alu_b),
    .ready    (div_ready),
    .result   (div_result)
  );

  execute_stage #(.xlen(xlen)) u_stage (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_rd      (issue_rd),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm),
    .flush         (flush),
    .stall         (stall),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .op_a          (op_a),
    .op_b          (op_b),
    .alu_op        (alu_op),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .alu_result    (alu_result),
    .div_start     (div_start),
    .div_abort     (div_abort),
    .div_want_rem  (div_want_rem),
    .div_ready     (div_ready),
    .div_result    (div_result),
    .result_valid  (result_valid),
    .result_rd     (result_rd),
    .result_data   (result_data)
  );

  // writeback one edge after the result register.
  register_file #(.xlen(xlen)) u_regfile (
    .clock    (clock),
    .reset    (reset),
    .rd_addr1 (rs1_addr),
    .rd_addr2 (rs2_addr),
    .rd_data1 (rf_data1),
    .rd_data2 (rf_data2),
    .wr_en    (result_valid),
    .wr_addr  (result_rd),
    .wr_data  (result_data)
  );

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
  parameter int xlen = 32
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            issue_valid,
  input  exec_pkg::alu_op_t               issue_op,
  input  logic [exec_pkg::REG_ADDR_W-1:0] issue_rs1,
  input  logic [exec_pkg::REG_ADDR_W-1:0] issue_rs2,
  input  logic [exec_pkg::REG_ADDR_W-1:0] issue_rd,
  input  logic [xlen-1:0]                 issue_imm,
  input  logic                            issue_use_imm,
  input  logic                            flush,
  output logic                            stall,
  output logic [exec_pkg::REG_ADDR_W-1:0] rs1_addr,
  output logic [exec_pkg::REG_ADDR_W-1:0] rs2_addr,
  input  logic [xlen-1:0]                 op_a,
  input  logic [xlen-1:0]                 op_b,
  output exec_pkg::alu_op_t               alu_op,
  output logic [xlen-1:0]                 alu_a,
  output logic [xlen-1:0]                 alu_b,
  input  logic [xlen-1:0]                 alu_result,
  output logic                            div_start,
  output logic                            div_abort,
  output logic                            div_want_rem,
  input  logic                            div_ready,
  input  logic [xlen-1:0]                 div_result,
  output logic                            result_valid,
  output logic [exec_pkg::REG_ADDR_W-1:0] result_rd,
  output logic [xlen-1:0]                 result_data
);

  exec_pkg::stage_state_t          state;
  exec_pkg::alu_op_t               instr_op;
  logic [exec_pkg::REG_ADDR_W-1:0] instr_rs1;
  logic [exec_pkg::REG_ADDR_W-1:0] instr_rs2;
  logic [exec_pkg::REG_ADDR_W-1:0] instr_rd;
  logic [xlen-1:0]                 instr_imm;
  logic                            instr_use_imm;
  logic                            issue_is_div;
  logic                            accept;
  logic                            alu_done;
  logic                            div_done;
  logic                            retire;

  assign issue_is_div = (issue_op == exec_pkg::OP_DIVU) || (issue_op == exec_pkg::OP_REMU);
  assign accept = issue_valid && !stall;

  // ready can still be high from the previous divide during the start cycle.
  assign stall = (state == exec_pkg::ST_DIV_WAIT) && (div_start || !div_ready);
  assign alu_done = (state == exec_pkg::ST_EXEC);
  assign div_done = (state == exec_pkg::ST_DIV_WAIT) && !div_start && div_ready;
  assign retire = (alu_done || div_done) && !flush;

  assign rs1_addr = instr_rs1;
  assign rs2_addr = instr_rs2;
  assign alu_op = instr_op;
  assign alu_a = op_a;
  assign alu_b = instr_use_imm ? instr_imm : op_b; // also the divisor.
  assign div_abort = flush;
  assign div_want_rem = (instr_op == exec_pkg::OP_REMU);

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= exec_pkg::ST_IDLE;
      div_start <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      div_start <= 1'b0;
      result_valid <= retire;
      if (flush) begin
        state <= exec_pkg::ST_IDLE;
      end else if (accept) begin
        state <= issue_is_div ? exec_pkg::ST_DIV_WAIT : exec_pkg::ST_EXEC;
        div_start <= issue_is_div; // operands are forwarded next cycle.
      end else if (retire) begin
        state <= exec_pkg::ST_IDLE;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      instr_op <= issue_op;
      instr_rs1 <= issue_rs1;
      instr_rs2 <= issue_rs2;
      instr_rd <= issue_rd;
      instr_imm <= issue_imm;
      instr_use_imm <= issue_use_imm;
    end
    if (retire) begin
      result_rd <= instr_rd;
      result_data <= div_done ? div_result : alu_result;
    end
  end

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file #(
  parameter int xlen = 32
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [exec_pkg::REG_ADDR_W-1:0] rd_addr1,
  input  logic [exec_pkg::REG_ADDR_W-1:0] rd_addr2,
  output logic [xlen-1:0]                 rd_data1,
  output logic [xlen-1:0]                 rd_data2,
  input  logic                            wr_en,
  input  logic [exec_pkg::REG_ADDR_W-1:0] wr_addr,
  input  logic [xlen-1:0]                 wr_data
);

  logic [xlen-1:0] regs [exec_pkg::NUM_REGS];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < exec_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1]; // x0 reads zero.
  assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

`default_nettype wire

// File: verilog/iter_divider.sv
`timescale 1ns/1ps
`default_nettype none

module iter_divider #(
  parameter int xlen = 32
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            start,
  input  logic            abort,
  input  logic            want_rem,
  input  logic [xlen-1:0] dividend,
  input  logic [xlen-1:0] divisor,
  output logic            ready,
  output logic [xlen-1:0] result
);

  localparam int CNT_W = $clog2(xlen + 1);

  logic             busy;
  logic [CNT_W-1:0] count;
  logic [xlen-1:0]  rem_q;
  logic [xlen-1:0]  quo_q;
  logic [xlen-1:0]  divisor_q;
  logic             rem_sel;
  logic [xlen:0]    partial;
  logic [xlen:0]    diff;

  // one restoring step, borrow in the top bit.
  assign partial = {rem_q, quo_q[xlen-1]};
  assign diff = partial - {1'b0, divisor_q};

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy <= 1'b0;
      ready <= 1'b0;
      count <= '0;
    end else if (abort) begin
      busy <= 1'b0;
      ready <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy <= 1'b1;
      ready <= 1'b0;
      count <= CNT_W'(xlen);
    end else if (busy) begin
      count <= count - CNT_W'(1);
      if (count == CNT_W'(1)) begin
        busy <= 1'b0;
        ready <= 1'b1; // held until next start.
      end
    end
  end

  // zero divisor never borrows, so quotient is all ones and rem the dividend.
  always_ff @(posedge clock) begin
    if (start) begin
      rem_q <= '0;
      quo_q <= dividend;
      divisor_q <= divisor;
      rem_sel <= want_rem;
    end else if (busy) begin
      rem_q <= diff[xlen] ? partial[xlen-1:0] : diff[xlen-1:0];
      quo_q <= {quo_q[xlen-2:0], ~diff[xlen]};
    end
  end

  assign result = rem_sel ? rem_q : quo_q;

endmodule

`default_nettype wire

// File: verilog/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu #(
  parameter int xlen = 32
) (
  input  exec_pkg::alu_op_t op,
  input  logic [xlen-1:0]   a,
  input  logic [xlen-1:0]   b,
  output logic [xlen-1:0]   result
);

  localparam int SHAMT_W = $clog2(xlen);

  logic [SHAMT_W-1:0] shamt;

  assign shamt = b[SHAMT_W-1:0];

  always_comb begin
    case (op)
      exec_pkg::OP_ADD:  result = a + b;
      exec_pkg::OP_SUB:  result = a - b;
      exec_pkg::OP_AND:  result = a & b;
      exec_pkg::OP_OR:   result = a | b;
      exec_pkg::OP_XOR:  result = a ^ b;
      exec_pkg::OP_SLL:  result = a << shamt;
      exec_pkg::OP_SRL:  result = a >> shamt;
      exec_pkg::OP_SRA:  result = $signed(a) >>> shamt;
      exec_pkg::OP_SLT:  result = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
      exec_pkg::OP_SLTU: result = {{(xlen-1){1'b0}}, (a < b)};
      exec_pkg::OP_LUI:  result = b;
      exec_pkg::OP_DIVU,
      exec_pkg::OP_REMU: result = '0; // taken from the divider.
      default:           result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward #(
  parameter int xlen = 32
) (
  input  logic [exec_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  logic [exec_pkg::REG_ADDR_W-1:0] rs2_addr,
  input  logic [xlen-1:0]                 rf_data1,
  input  logic [xlen-1:0]                 rf_data2,
  input  logic                            fwd_valid,
  input  logic [exec_pkg::REG_ADDR_W-1:0] fwd_rd,
  input  logic [xlen-1:0]                 fwd_data,
  output logic [xlen-1:0]                 op_a,
  output logic [xlen-1:0]                 op_b
);

  logic hit1;
  logic hit2;

  // result register is one edge ahead of the register file.
  assign hit1 = fwd_valid && (fwd_rd == rs1_addr) && (rs1_addr != '0);
  assign hit2 = fwd_valid && (fwd_rd == rs2_addr) && (rs2_addr != '0);

  assign op_a = hit1 ? fwd_data : rf_data1;
  assign op_b = hit2 ? fwd_data : rf_data2;

endmodule

`default_nettype wire

// File: verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

  localparam int REG_ADDR_W = 4; // x0 to x15.
  localparam int NUM_REGS = 16;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_SLT  = 4'd8,
    OP_SLTU = 4'd9,
    OP_LUI  = 4'd10, // imm arrives already shifted.
    OP_DIVU = 4'd11,
    OP_REMU = 4'd12
  } alu_op_t;

  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_EXEC     = 2'd1, // alu op, retires at next edge.
    ST_DIV_WAIT = 2'd2
  } stage_state_t;

endpackage

`default_nettype wire
